// ==== common/zxuno_bus_if.sv ====
`timescale 1ns/1ps

interface zxuno_bus_if;
   import zxuno_pkg::*;

   // currently selected register
   zxbyte_t reg_num;
   // data port read in progress
   logic    regrd;
   // data port write in progress
   logic    regwr;
   // byte being written by the cpu
   zxbyte_t wdata;

   // port decoder owns every signal
   modport decoder (output reg_num, output regrd, output regwr, output wdata);

   // register slots watch the whole bus
   modport slot (input reg_num, input regrd, input regwr, input wdata);

   // read mux only needs the number and the read strobe
   modport readback (input reg_num, input regrd);

endinterface

// ==== common/zxuno_pkg.sv ====
package zxuno_pkg;

   // --------------------
   // bus types
   // --------------------

   // full z80 address word
   typedef logic [15:0] cpu_addr_t;

   // one data byte on the z80 bus
   typedef logic [7:0] zxbyte_t;

   // --------------------
   // port map
   // --------------------

   // register number is written here
   localparam cpu_addr_t ZXUNO_ADDR_PORT = 16'hFC3B;

   // selected register is read and written here
   localparam cpu_addr_t ZXUNO_DATA_PORT = 16'hFD3B;

   // pulled-up bus value when no device answers
   localparam zxbyte_t IDLE_BUS = 8'hFF;

   // --------------------
   // register slots
   // --------------------

   // number of configuration registers in the bank
   localparam int NUM_SLOTS = 4;

   // slot indices
   localparam int SLOT_SCNDBL = 0;
   localparam int SLOT_RLINE  = 1;
   localparam int SLOT_RCTRL  = 2;
   localparam int SLOT_DEVOPT = 3;

   // register number answered by each slot
   localparam zxbyte_t SLOT_REG_NUM [NUM_SLOTS] = '{8'h0B, 8'h0C, 8'h0D, 8'h0E};

   // power-up contents per slot
   // raster control 01 keeps line 511 selected so no raster int fires
   localparam zxbyte_t SLOT_RESET [NUM_SLOTS] = '{8'h00, 8'hFF, 8'h01, 8'h00};

   // --------------------
   // field positions
   // --------------------

   // scandoubler control, register 0B
   localparam int SCNDBL_VGA_BIT   = 0;
   localparam int SCNDBL_SCANL_BIT = 1;
   // 3-bit master clock frequency select
   localparam int SCNDBL_FREQ_LSB  = 2;
   localparam int SCNDBL_CSYNC_BIT = 5;
   // 2-bit cpu speed select
   localparam int SCNDBL_TURBO_LSB = 6;

   // raster control, register 0D
   // line bit 8 sits above the 0C byte
   localparam int RCTRL_LINE8_BIT  = 0;
   localparam int RCTRL_ENABLE_BIT = 1;
   localparam int RCTRL_VRDIS_BIT  = 2;

   // --------------------
   // device options
   // --------------------

   // register 0E as named flags, msb first
   typedef struct packed {
      logic enable_timexmmu;
      logic disable_spisd;
      logic disable_romsel1f;
      logic disable_romsel7f;
      logic disable_1ffd;
      logic disable_7ffd;
      logic disable_turboay;
      logic disable_ay;
   } dev_options_t;

   // same byte seen as raw data or as flags
   typedef union packed {
      zxbyte_t      raw;
      dev_options_t flags;
   } dev_options_u;

endpackage

// ==== dv/tb_zxuno_regs.sv ====
`timescale 1ns/1ps

module tb_zxuno_regs;
   import zxuno_pkg::*;

   logic         sysclk;
   logic         reset;
   cpu_addr_t    a;
   logic         iorq_n;
   logic         rd_n;
   logic         wr_n;
   zxbyte_t      din;
   zxbyte_t      dout;
   logic         vga_enable;
   logic         scanlines_enable;
   logic [2:0]   freq_option;
   logic         csync_option;
   logic [1:0]   turbo_option;
   logic [8:0]   raster_line;
   logic         rasterint_enable;
   logic         vretraceint_disable;
   logic         disable_ay;
   logic         disable_turboay;
   logic         disable_7ffd;
   logic         disable_1ffd;
   logic         disable_romsel7f;
   logic         disable_romsel1f;
   logic         disable_spisd;
   logic         enable_timexmmu;

   // reference model of the register bank
   zxbyte_t      model_regs [256];
   zxbyte_t      model_reg_num;

   logic [15:0]  lfsr;
   int           error_count;
   int           timeout_count;

   zxuno_regs_top DUT (.*);

   // 20 ns clock
   initial begin
      sysclk = 1'b0;
      forever #10 sysclk = ~sysclk;
   end

   // --------------------
   // random source
   // --------------------

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[14:0], lfsr[0]};
      end
   endtask

   // --------------------
   // compare tasks
   // --------------------

   task automatic check_byte(input string name, input zxbyte_t exp, input zxbyte_t act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_options(input string name, input dev_options_t exp,
                                input dev_options_t act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         error_count++;
      end
   endtask

   // multi-bit fields, zero extended by the caller
   task automatic check_field(input string name, input logic [8:0] exp, input logic [8:0] act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         error_count++;
      end
   endtask

   // --------------------
   // model
   // --------------------

   function automatic logic is_mapped(input zxbyte_t n);
      return (n >= 8'h0B) && (n <= 8'h0E);
   endfunction

   // power-up contents of the four registers
   task automatic model_reset();
      model_regs[8'h0B] = 8'h00;
      model_regs[8'h0C] = 8'hFF;
      model_regs[8'h0D] = 8'h01;
      model_regs[8'h0E] = 8'h00;
      model_reg_num     = 8'h00;
   endtask

   // --------------------
   // z80 io cycles
   // --------------------

   // strobes held one cycle, then one idle cycle
   task automatic io_write(input cpu_addr_t port, input zxbyte_t data, input logic use_iorq);
      a      = port;
      din    = data;
      iorq_n = ~use_iorq;
      wr_n   = 1'b0;
      @(posedge sysclk);
      #2;
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      @(posedge sysclk);
      #2;
   endtask

   // dout sampled on the falling edge, mid access
   task automatic io_read(input cpu_addr_t port, output zxbyte_t data);
      a      = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      @(negedge sysclk);
      data = dout;
      @(posedge sysclk);
      #2;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      @(posedge sysclk);
      #2;
   endtask

   task automatic write_reg_num(input zxbyte_t n);
      io_write(ZXUNO_ADDR_PORT, n, 1'b1);
      model_reg_num = n;
   endtask

   task automatic write_data(input zxbyte_t d);
      io_write(ZXUNO_DATA_PORT, d, 1'b1);
      if (is_mapped(model_reg_num)) model_regs[model_reg_num] = d;
   endtask

   // data port read against the model
   task automatic expect_data(input string name);
      zxbyte_t d;
      io_read(ZXUNO_DATA_PORT, d);
      check_byte(name, is_mapped(model_reg_num) ? model_regs[model_reg_num] : 8'hFF, d);
   endtask

   task automatic expect_reg_num(input string name);
      zxbyte_t d;
      io_read(ZXUNO_ADDR_PORT, d);
      check_byte(name, model_reg_num, d);
   endtask

   // every configuration output against its model field
   task automatic check_outputs(input string name);
      dev_options_u exp_opts;
      dev_options_t act_opts;
      zxbyte_t      scn;
      zxbyte_t      rctl;
      scn  = model_regs[8'h0B];
      rctl = model_regs[8'h0D];
      check_bit({name, " vga_enable"}, scn[0], vga_enable);
      check_bit({name, " scanlines_enable"}, scn[1], scanlines_enable);
      check_field({name, " freq_option"}, {6'b0, scn[4:2]}, {6'b0, freq_option});
      check_bit({name, " csync_option"}, scn[5], csync_option);
      check_field({name, " turbo_option"}, {7'b0, scn[7:6]}, {7'b0, turbo_option});
      // line bit 8 from 0D above the 0C byte
      check_field({name, " raster_line"}, {rctl[0], model_regs[8'h0C]}, raster_line);
      check_bit({name, " rasterint_enable"}, rctl[1], rasterint_enable);
      check_bit({name, " vretraceint_disable"}, rctl[2], vretraceint_disable);
      exp_opts.raw = model_regs[8'h0E];
      act_opts = {enable_timexmmu, disable_spisd, disable_romsel1f, disable_romsel7f,
                  disable_1ffd, disable_7ffd, disable_turboay, disable_ay};
      check_options({name, " dev_options"}, exp_opts.flags, act_opts);
   endtask

   // bounded wait for the reset contents to show on the outputs
   task automatic wait_reset_state(input string name);
      int cycles;
      cycles = 0;
      while (!(raster_line == 9'h1FF && !rasterint_enable) && cycles < 10) begin
         @(posedge sysclk);
         #2;
         cycles++;
      end
      if (!(raster_line == 9'h1FF && !rasterint_enable)) begin
         $display("%s: outputs never reached their reset state", name);
         timeout_count++;
      end
   endtask

   task automatic check_reset_state(input string name);
      zxbyte_t n;
      wait_reset_state(name);
      expect_reg_num({name, " reg number"});
      for (int k = 0; k < 4; k++) begin
         n = 8'h0B + k[7:0];
         write_reg_num(n);
         expect_data($sformatf("%s reg %h", name, n));
      end
      check_outputs(name);
   endtask

   // --------------------
   // test sequence
   // --------------------

   initial begin
      logic [15:0] r;
      logic [15:0] sel;
      cpu_addr_t   p;
      zxbyte_t     d;
      reset = 1'b1;
      a = '0;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      din = '0;
      lfsr = 16'd18;
      error_count = 0;
      timeout_count = 0;
      model_reset();
      repeat (2) @(posedge sysclk);
      #2;
      reset = 1'b0;

      check_reset_state("after reset");

      // register number round trip
      for (int i = 0; i < 8; i++) begin
         rand_bits(8, r);
         write_reg_num(r[7:0]);
         expect_reg_num("addr port readback");
      end

      // mapped numbers mixed with random others
      for (int i = 0; i < 60; i++) begin
         rand_bits(1, sel);
         rand_bits(8, r);
         if (sel[0]) write_reg_num(8'h0B + {6'b0, r[1:0]});
         else write_reg_num(r[7:0]);
         rand_bits(1, sel);
         rand_bits(8, r);
         if (sel[0]) write_data(r[7:0]);
         expect_data($sformatf("data port reg %h", model_reg_num));
      end

      // foreign ports read as idle bus
      for (int i = 0; i < 10; i++) begin
         rand_bits(16, r);
         p = r;
         if (p == ZXUNO_ADDR_PORT || p == ZXUNO_DATA_PORT) p = p ^ 16'h8000;
         if (i == 0) p = 16'hFC3A;
         if (i == 1) p = 16'hFD3F;
         io_read(p, d);
         check_byte($sformatf("foreign port %h", p), 8'hFF, d);
      end

      // writes without iorq are ignored
      write_reg_num(8'h0C);
      rand_bits(8, r);
      io_write(ZXUNO_DATA_PORT, r[7:0], 1'b0);
      io_write(ZXUNO_ADDR_PORT, r[7:0] ^ 8'h5A, 1'b0);
      expect_reg_num("no iorq reg number");
      expect_data("no iorq data");
      check_outputs("no iorq");

      // configuration outputs follow the written bytes
      for (int i = 0; i < 10; i++) begin
         for (int k = 0; k < 4; k++) begin
            rand_bits(8, r);
            write_reg_num(8'h0B + k[7:0]);
            write_data(r[7:0]);
         end
         check_outputs("config outputs");
      end

      // synchronous reset mid run
      reset = 1'b1;
      repeat (2) @(posedge sysclk);
      #2;
      reset = 1'b0;
      model_reset();
      check_reset_state("mid-run reset");

      $display("value errors: %0d, timeouts: %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== logic/zxuno_regs_top.sv ====
`timescale 1ns/1ps

module zxuno_regs_top (
   input  logic                 sysclk,
   input  logic                 reset,

   // z80 io bus
   input  zxuno_pkg::cpu_addr_t a,
   input  logic                 iorq_n,
   input  logic                 rd_n,
   input  logic                 wr_n,
   input  zxuno_pkg::zxbyte_t   din,
   output zxuno_pkg::zxbyte_t   dout,

   // scandoubler control
   output logic                 vga_enable,
   output logic                 scanlines_enable,
   output logic [2:0]           freq_option,
   output logic                 csync_option,
   output logic [1:0]           turbo_option,

   // raster interrupt control
   output logic [8:0]           raster_line,
   output logic                 rasterint_enable,
   output logic                 vretraceint_disable,

   // device enables
   output logic                 disable_ay,
   output logic                 disable_turboay,
   output logic                 disable_7ffd,
   output logic                 disable_1ffd,
   output logic                 disable_romsel7f,
   output logic                 disable_romsel1f,
   output logic                 disable_spisd,
   output logic                 enable_timexmmu
);
   import zxuno_pkg::*;

   // address port read in progress
   logic                 addr_rd;

   // per-slot contents and read hits
   zxbyte_t              slot_value [NUM_SLOTS];
   logic [NUM_SLOTS-1:0] slot_hit;

   // device options as a flag group
   dev_options_t         dev_options;

   // register bus between decoder, slots and readback
   zxuno_bus_if regbus ();

   // --------------------
   // port decode
   // --------------------

   zxuno_addr_decoder u_decoder (
      .sysclk  (sysclk),
      .reset   (reset),
      .a       (a),
      .iorq_n  (iorq_n),
      .rd_n    (rd_n),
      .wr_n    (wr_n),
      .din     (din),
      .addr_rd (addr_rd),
      .bus     (regbus.decoder)
   );

   // --------------------
   // register slots
   // --------------------

   // one slot per table entry in the package
   for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
      config_register #(
         .reg_num     (SLOT_REG_NUM[i]),
         .reset_value (SLOT_RESET[i])
      ) u_slot (
         .sysclk (sysclk),
         .reset  (reset),
         .bus    (regbus.slot),
         .value  (slot_value[i]),
         .hit    (slot_hit[i])
      );
   end

   // --------------------
   // readback and fields
   // --------------------

   zxuno_reg_outputs u_outputs (
      .bus                 (regbus.readback),
      .addr_rd             (addr_rd),
      .slot_value          (slot_value),
      .slot_hit            (slot_hit),
      .dout                (dout),
      .vga_enable          (vga_enable),
      .scanlines_enable    (scanlines_enable),
      .freq_option         (freq_option),
      .csync_option        (csync_option),
      .turbo_option        (turbo_option),
      .raster_line         (raster_line),
      .rasterint_enable    (rasterint_enable),
      .vretraceint_disable (vretraceint_disable),
      .dev_options         (dev_options)
   );

   // flag group split into board-level pins
   assign disable_ay       = dev_options.disable_ay;
   assign disable_turboay  = dev_options.disable_turboay;
   assign disable_7ffd     = dev_options.disable_7ffd;
   assign disable_1ffd     = dev_options.disable_1ffd;
   assign disable_romsel7f = dev_options.disable_romsel7f;
   assign disable_romsel1f = dev_options.disable_romsel1f;
   assign disable_spisd    = dev_options.disable_spisd;
   assign enable_timexmmu  = dev_options.enable_timexmmu;

endmodule

// ==== regbank/config_register.sv ====
`timescale 1ns/1ps

module config_register #(
   // register number this slot answers to
   parameter zxuno_pkg::zxbyte_t reg_num     = 8'h00,
   // contents after reset
   parameter zxuno_pkg::zxbyte_t reset_value = 8'h00
) (
   input  logic               sysclk,
   input  logic               reset,
   zxuno_bus_if.slot          bus,
   output zxuno_pkg::zxbyte_t value,
   output logic               hit
);

   // selected register is this one
   logic match;

   assign match = (bus.reg_num == reg_num);

   // --------------------
   // storage
   // --------------------

   // load on a data port write to our number
   always_ff @(posedge sysclk) begin
      if (reset) begin
         value <= reset_value;
      end else if (bus.regwr && match) begin
         value <= bus.wdata;
      end
   end

   // --------------------
   // readback request
   // --------------------

   // combinational so the read mux sees it in the same cycle
   assign hit = bus.regrd & match;

endmodule

// ==== regbank/zxuno_addr_decoder.sv ====
`timescale 1ns/1ps

module zxuno_addr_decoder (
   input  logic                 sysclk,
   input  logic                 reset,
   input  zxuno_pkg::cpu_addr_t a,
   input  logic                 iorq_n,
   input  logic                 rd_n,
   input  logic                 wr_n,
   input  zxuno_pkg::zxbyte_t   din,
   output logic                 addr_rd,
   zxuno_bus_if.decoder         bus
);
   import zxuno_pkg::*;

   // qualified z80 io cycles
   logic    io_rd;
   logic    io_wr;

   // port matches on the full 16-bit address
   logic    sel_addr;
   logic    sel_data;

   // register number latch
   zxbyte_t reg_num_q;

   // --------------------
   // io cycle decode
   // --------------------

   // strobes are active low
   assign io_rd = ~iorq_n & ~rd_n;
   assign io_wr = ~iorq_n & ~wr_n;

   // no partial decode, both ports need all 16 bits
   assign sel_addr = (a == ZXUNO_ADDR_PORT);
   assign sel_data = (a == ZXUNO_DATA_PORT);

   // --------------------
   // register number
   // --------------------

   // loaded on an address port write
   // a held write just reloads the same byte
   always_ff @(posedge sysclk) begin
      if (reset) begin
         reg_num_q <= '0;
      end else if (sel_addr && io_wr) begin
         reg_num_q <= din;
      end
   end

   // --------------------
   // bus outputs
   // --------------------

   // cpu reading back the register number
   assign addr_rd = sel_addr & io_rd;

   assign bus.reg_num = reg_num_q;

   // level strobes for the data port, no handshake
   assign bus.regrd = sel_data & io_rd;
   assign bus.regwr = sel_data & io_wr;

   // write data straight from the cpu bus
   assign bus.wdata = din;

endmodule

// ==== regbank/zxuno_reg_outputs.sv ====
`timescale 1ns/1ps

module zxuno_reg_outputs (
   zxuno_bus_if.readback            bus,
   input  logic                     addr_rd,
   input  zxuno_pkg::zxbyte_t       slot_value [zxuno_pkg::NUM_SLOTS],
   input  logic [zxuno_pkg::NUM_SLOTS-1:0] slot_hit,
   output zxuno_pkg::zxbyte_t       dout,
   output logic                     vga_enable,
   output logic                     scanlines_enable,
   output logic [2:0]               freq_option,
   output logic                     csync_option,
   output logic [1:0]               turbo_option,
   output logic [8:0]               raster_line,
   output logic                     rasterint_enable,
   output logic                     vretraceint_disable,
   output zxuno_pkg::dev_options_t  dev_options
);
   import zxuno_pkg::*;

   // device options byte seen as flags
   dev_options_u devopt_view;

   // --------------------
   // cpu read data
   // --------------------

   // idle bus unless someone answers
   // scan from the top so the lowest hit slot wins
   // address port read overrides everything
   always_comb begin
      dout = IDLE_BUS;
      for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
         // hits only count during a data port read
         if (bus.regrd && slot_hit[i]) begin
            dout = slot_value[i];
         end
      end
      if (addr_rd) begin
         dout = bus.reg_num;
      end
   end

   // --------------------
   // scandoubler fields
   // --------------------

   assign vga_enable       = slot_value[SLOT_SCNDBL][SCNDBL_VGA_BIT];
   assign scanlines_enable = slot_value[SLOT_SCNDBL][SCNDBL_SCANL_BIT];
   // master clock frequency select
   assign freq_option      = slot_value[SLOT_SCNDBL][SCNDBL_FREQ_LSB +: 3];
   assign csync_option     = slot_value[SLOT_SCNDBL][SCNDBL_CSYNC_BIT];
   // cpu speed select
   assign turbo_option     = slot_value[SLOT_SCNDBL][SCNDBL_TURBO_LSB +: 2];

   // --------------------
   // raster interrupt
   // --------------------

   // line bit 8 lives in the control register
   assign raster_line = {slot_value[SLOT_RCTRL][RCTRL_LINE8_BIT], slot_value[SLOT_RLINE]};

   assign rasterint_enable    = slot_value[SLOT_RCTRL][RCTRL_ENABLE_BIT];
   assign vretraceint_disable = slot_value[SLOT_RCTRL][RCTRL_VRDIS_BIT];

   // --------------------
   // device options
   // --------------------

   // raw byte in, named flags out
   always_comb begin
      devopt_view.raw = slot_value[SLOT_DEVOPT];
   end

   assign dev_options = devopt_view.flags;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the register bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_zxuno_regs -f sources.f -o tb_zxuno_regs

output=$(./obj_dir/tb_zxuno_regs)
echo "$output"

# pass only if the testbench printed the pass line
echo "$output" | grep -q "^Test passed$"

// ==== sources.f ====
common/zxuno_pkg.sv
common/zxuno_bus_if.sv
regbank/zxuno_addr_decoder.sv
regbank/config_register.sv
regbank/zxuno_reg_outputs.sv
logic/zxuno_regs_top.sv
dv/tb_zxuno_regs.sv
